//--- logic/ext_mux_pkg.sv
//////////////////////////////
// Shared constants for the AXI4-Lite port multiplexer
// Port count and index width, bus widths, in-flight limit
// and the response codes
//////////////////////////////

package ext_mux_pkg;

  //////////////////////////////
  // Requester ports
  //////////////////////////////

  localparam int unsigned NUM_PORTS  = 4;
  localparam int unsigned PORT_IDX_W = 2;  // Enough bits for NUM_PORTS

  //////////////////////////////
  // Bus widths
  //////////////////////////////

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned STRB_W = DATA_W / 8;

  //////////////////////////////
  // Outstanding transactions
  //////////////////////////////

  // Per direction, and also the source FIFO depth
  localparam int unsigned MAX_OUTSTANDING = 8;
  localparam int unsigned FIFO_CNT_W      = 4;  // Holds 0 to MAX_OUTSTANDING

  //////////////////////////////
  // Response codes
  //////////////////////////////

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

//--- logic/rr_arbiter.sv
//////////////////////////////
// Round-robin arbiter with a registered grant
// Grant stays fixed while hold_i is high
//////////////////////////////

`timescale 1ns/1ps

module rr_arbiter (
  input  logic                                periph_clk,
  input  logic                                rst_i,
  input  logic [ext_mux_pkg::NUM_PORTS-1:0]   req_i,
  input  logic                                hold_i,
  output logic                                gnt_valid_o,
  output logic [ext_mux_pkg::PORT_IDX_W-1:0]  gnt_idx_o
);

  import ext_mux_pkg::*;

  logic                  gnt_valid_q;
  logic [PORT_IDX_W-1:0] gnt_idx_q;  // Also remembers the last winner
  logic [PORT_IDX_W-1:0] next_idx;

  // Search starts one past the last winner, nearest requester wins
  always_comb begin
    next_idx = gnt_idx_q;
    for (int off = NUM_PORTS; off >= 1; off--) begin
      if (req_i[(int'(gnt_idx_q) + off) % NUM_PORTS]) begin
        next_idx = PORT_IDX_W'((int'(gnt_idx_q) + off) % NUM_PORTS);
      end
    end
  end

  always_ff @(posedge periph_clk) begin
    if (rst_i) begin
      gnt_valid_q <= 1'b0;
      gnt_idx_q   <= PORT_IDX_W'(NUM_PORTS - 1);  // Port 0 goes first
    end else if (!hold_i) begin
      gnt_valid_q <= |req_i;
      if (|req_i) begin
        gnt_idx_q <= next_idx;
      end
    end
  end

  assign gnt_valid_o = gnt_valid_q;
  assign gnt_idx_o   = gnt_idx_q;

  // Any other requester beats the last winner
  assert property (@(posedge periph_clk) disable iff (rst_i)
    ((req_i & ~(NUM_PORTS'(1) << gnt_idx_q)) != '0) |->
      req_i[next_idx] && (next_idx != gnt_idx_q))
    else $error("rr_arbiter picked %0h over other requests, last %0h", next_idx, gnt_idx_q);

endmodule

//--- logic/source_fifo.sv
//////////////////////////////
// FIFO of requester port indices
// One entry per outstanding transaction, head names
// the port that owns the next response
//////////////////////////////

`timescale 1ns/1ps

module source_fifo (
  input  logic                                periph_clk,
  input  logic                                rst_i,
  input  logic                                push_i,
  input  logic [ext_mux_pkg::PORT_IDX_W-1:0]  push_idx_i,
  input  logic                                pop_i,
  output logic [ext_mux_pkg::PORT_IDX_W-1:0]  head_idx_o,
  output logic                                full_o,
  output logic                                empty_o
);

  import ext_mux_pkg::*;

  logic [PORT_IDX_W-1:0] mem_q [MAX_OUTSTANDING];
  logic [FIFO_CNT_W-2:0] wr_ptr_q;
  logic [FIFO_CNT_W-2:0] rd_ptr_q;
  logic [FIFO_CNT_W-1:0] cnt_q;
  logic [FIFO_CNT_W-1:0] cnt_d;

  assign cnt_d = cnt_q + FIFO_CNT_W'(push_i) - FIFO_CNT_W'(pop_i);

  assign head_idx_o = mem_q[rd_ptr_q];
  assign empty_o    = (cnt_q == '0);
  // Looks at this cycle's push and pop so a grant issued now finds a slot
  assign full_o     = (cnt_d == FIFO_CNT_W'(MAX_OUTSTANDING));

  always_ff @(posedge periph_clk) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      cnt_q <= cnt_d;
      if (push_i) begin
        wr_ptr_q <= (int'(wr_ptr_q) == MAX_OUTSTANDING - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (int'(rd_ptr_q) == MAX_OUTSTANDING - 1) ? '0 : rd_ptr_q + 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge periph_clk) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_idx_i;
    end
  end

  // Slot freed by a pop in the same cycle may be reused
  assert property (@(posedge periph_clk) disable iff (rst_i)
    push_i |-> (cnt_q != FIFO_CNT_W'(MAX_OUTSTANDING)) || pop_i)
    else $error("source_fifo push while full, cnt %0h", cnt_q);

  assert property (@(posedge periph_clk) disable iff (rst_i)
    pop_i |-> !empty_o)
    else $error("source_fifo pop while empty");

endmodule

//--- logic/write_mux.sv
//////////////////////////////
// Write path of the port multiplexer
// AW and W arbitration and forwarding,
// B routed back through the source FIFO
//////////////////////////////

`timescale 1ns/1ps

module write_mux (
  input  logic                                                  periph_clk,
  input  logic                                                  rst_i,
  // Requester side
  input  logic [ext_mux_pkg::NUM_PORTS-1:0]                     s_awvalid_i,
  output logic [ext_mux_pkg::NUM_PORTS-1:0]                     s_awready_o,
  input  logic [ext_mux_pkg::NUM_PORTS-1:0][ext_mux_pkg::ADDR_W-1:0] s_awaddr_i,
  input  logic [ext_mux_pkg::NUM_PORTS-1:0]                     s_wvalid_i,
  output logic [ext_mux_pkg::NUM_PORTS-1:0]                     s_wready_o,
  input  logic [ext_mux_pkg::NUM_PORTS-1:0][ext_mux_pkg::DATA_W-1:0] s_wdata_i,
  input  logic [ext_mux_pkg::NUM_PORTS-1:0][ext_mux_pkg::STRB_W-1:0] s_wstrb_i,
  output logic [ext_mux_pkg::NUM_PORTS-1:0]                     s_bvalid_o,
  input  logic [ext_mux_pkg::NUM_PORTS-1:0]                     s_bready_i,
  output logic [ext_mux_pkg::NUM_PORTS-1:0][1:0]                s_bresp_o,
  // Subordinate side
  output logic                                                  m_awvalid_o,
  input  logic                                                  m_awready_i,
  output logic [ext_mux_pkg::ADDR_W-1:0]                        m_awaddr_o,
  output logic                                                  m_wvalid_o,
  input  logic                                                  m_wready_i,
  output logic [ext_mux_pkg::DATA_W-1:0]                        m_wdata_o,
  output logic [ext_mux_pkg::STRB_W-1:0]                        m_wstrb_o,
  input  logic                                                  m_bvalid_i,
  output logic                                                  m_bready_o,
  input  logic [1:0]                                            m_bresp_i
);

  import ext_mux_pkg::*;

  logic                  gnt_valid;
  logic [PORT_IDX_W-1:0] gnt_idx;
  logic [NUM_PORTS-1:0]  arb_req;
  logic                  arb_hold;
  logic                  aw_done_q;
  logic                  w_done_q;
  logic                  aw_fire;
  logic                  w_fire;
  logic                  txn_done;
  logic                  b_fire;
  logic                  fifo_full;
  logic                  fifo_empty;
  logic [PORT_IDX_W-1:0] head_idx;

  // A port needs AW and W together, the current owner is left out
  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      arb_req[i] = s_awvalid_i[i] & s_wvalid_i[i] & ~fifo_full &
                   ~(gnt_valid && gnt_idx == PORT_IDX_W'(i));
    end
  end

  rr_arbiter u_arbiter (
    .periph_clk  (periph_clk),
    .rst_i       (rst_i),
    .req_i       (arb_req),
    .hold_i      (arb_hold),
    .gnt_valid_o (gnt_valid),
    .gnt_idx_o   (gnt_idx)
  );

  //////////////////////////////
  // AW and W forwarding
  //////////////////////////////

  assign m_awvalid_o = gnt_valid & ~aw_done_q;
  assign m_wvalid_o  = gnt_valid & ~w_done_q;
  assign m_awaddr_o  = s_awaddr_i[gnt_idx];
  assign m_wdata_o   = s_wdata_i[gnt_idx];
  assign m_wstrb_o   = s_wstrb_i[gnt_idx];

  assign aw_fire  = m_awvalid_o & m_awready_i;
  assign w_fire   = m_wvalid_o & m_wready_i;
  assign txn_done = gnt_valid & (aw_done_q | aw_fire) & (w_done_q | w_fire);
  assign arb_hold = gnt_valid & ~txn_done;

  always_ff @(posedge periph_clk) begin
    if (rst_i) begin
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
    end else if (txn_done) begin
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
    end else begin
      aw_done_q <= aw_done_q | aw_fire;
      w_done_q  <= w_done_q | w_fire;
    end
  end

  //////////////////////////////
  // B return
  //////////////////////////////

  assign m_bready_o = s_bready_i[head_idx] & ~fifo_empty;
  assign b_fire     = m_bvalid_i & m_bready_o;

  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      s_awready_o[i] = m_awready_i & m_awvalid_o & (gnt_idx == PORT_IDX_W'(i));
      s_wready_o[i]  = m_wready_i & m_wvalid_o & (gnt_idx == PORT_IDX_W'(i));
      s_bvalid_o[i]  = m_bvalid_i & ~fifo_empty & (head_idx == PORT_IDX_W'(i));
      s_bresp_o[i]   = m_bresp_i;
    end
  end

  source_fifo u_src_fifo (
    .periph_clk (periph_clk),
    .rst_i      (rst_i),
    .push_i     (aw_fire),  // Owner recorded at address acceptance
    .push_idx_i (gnt_idx),
    .pop_i      (b_fire),
    .head_idx_o (head_idx),
    .full_o     (fifo_full),
    .empty_o    (fifo_empty)
  );

  // A B beat with nothing accepted means the subordinate invented a response
  assert property (@(posedge periph_clk) disable iff (rst_i)
    m_bvalid_i |-> !fifo_empty)
    else $error("write_mux m_bvalid_i with no write outstanding, bresp %0h", m_bresp_i);

endmodule

//--- logic/read_mux.sv
//////////////////////////////
// Read path of the port multiplexer
// AR arbitration and forwarding,
// R routed back through the source FIFO
//////////////////////////////

`timescale 1ns/1ps

module read_mux (
  input  logic                                                  periph_clk,
  input  logic                                                  rst_i,
  // Requester side
  input  logic [ext_mux_pkg::NUM_PORTS-1:0]                     s_arvalid_i,
  output logic [ext_mux_pkg::NUM_PORTS-1:0]                     s_arready_o,
  input  logic [ext_mux_pkg::NUM_PORTS-1:0][ext_mux_pkg::ADDR_W-1:0] s_araddr_i,
  output logic [ext_mux_pkg::NUM_PORTS-1:0]                     s_rvalid_o,
  input  logic [ext_mux_pkg::NUM_PORTS-1:0]                     s_rready_i,
  output logic [ext_mux_pkg::NUM_PORTS-1:0][ext_mux_pkg::DATA_W-1:0] s_rdata_o,
  output logic [ext_mux_pkg::NUM_PORTS-1:0][1:0]                s_rresp_o,
  // Subordinate side
  output logic                                                  m_arvalid_o,
  input  logic                                                  m_arready_i,
  output logic [ext_mux_pkg::ADDR_W-1:0]                        m_araddr_o,
  input  logic                                                  m_rvalid_i,
  output logic                                                  m_rready_o,
  input  logic [ext_mux_pkg::DATA_W-1:0]                        m_rdata_i,
  input  logic [1:0]                                            m_rresp_i
);

  import ext_mux_pkg::*;

  logic                  gnt_valid;
  logic [PORT_IDX_W-1:0] gnt_idx;
  logic [NUM_PORTS-1:0]  arb_req;
  logic                  arb_hold;
  logic                  ar_fire;
  logic                  r_fire;
  logic                  fifo_full;
  logic                  fifo_empty;
  logic [PORT_IDX_W-1:0] head_idx;

  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      arb_req[i] = s_arvalid_i[i] & ~fifo_full &
                   ~(gnt_valid && gnt_idx == PORT_IDX_W'(i));  // Owner sits out
    end
  end

  rr_arbiter u_arbiter (
    .periph_clk  (periph_clk),
    .rst_i       (rst_i),
    .req_i       (arb_req),
    .hold_i      (arb_hold),
    .gnt_valid_o (gnt_valid),
    .gnt_idx_o   (gnt_idx)
  );

  // Single address beat, grant ends on AR handshake
  assign m_arvalid_o = gnt_valid;
  assign m_araddr_o  = s_araddr_i[gnt_idx];
  assign ar_fire     = m_arvalid_o & m_arready_i;
  assign arb_hold    = gnt_valid & ~ar_fire;

  assign m_rready_o = s_rready_i[head_idx] & ~fifo_empty;
  assign r_fire     = m_rvalid_i & m_rready_o;

  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      s_arready_o[i] = m_arready_i & m_arvalid_o & (gnt_idx == PORT_IDX_W'(i));
      s_rvalid_o[i]  = m_rvalid_i & ~fifo_empty & (head_idx == PORT_IDX_W'(i));
      s_rdata_o[i]   = m_rdata_i;
      s_rresp_o[i]   = m_rresp_i;
    end
  end

  source_fifo u_src_fifo (
    .periph_clk (periph_clk),
    .rst_i      (rst_i),
    .push_i     (ar_fire),
    .push_idx_i (gnt_idx),
    .pop_i      (r_fire),
    .head_idx_o (head_idx),
    .full_o     (fifo_full),
    .empty_o    (fifo_empty)
  );

  assert property (@(posedge periph_clk) disable iff (rst_i)
    m_rvalid_i |-> !fifo_empty)
    else $error("read_mux m_rvalid_i with no read outstanding, rresp %0h", m_rresp_i);

endmodule

//--- logic/axil_port_mux.sv
//////////////////////////////
// AXI4-Lite port multiplexer, top level
// Four requester ports onto one subordinate port
//////////////////////////////

`timescale 1ns/1ps

module axil_port_mux (
  input  logic                                                  periph_clk,
  input  logic                                                  rst_i,
  // Requester write channels
  input  logic [ext_mux_pkg::NUM_PORTS-1:0]                     s_awvalid_i,
  output logic [ext_mux_pkg::NUM_PORTS-1:0]                     s_awready_o,
  input  logic [ext_mux_pkg::NUM_PORTS-1:0][ext_mux_pkg::ADDR_W-1:0] s_awaddr_i,
  input  logic [ext_mux_pkg::NUM_PORTS-1:0]                     s_wvalid_i,
  output logic [ext_mux_pkg::NUM_PORTS-1:0]                     s_wready_o,
  input  logic [ext_mux_pkg::NUM_PORTS-1:0][ext_mux_pkg::DATA_W-1:0] s_wdata_i,
  input  logic [ext_mux_pkg::NUM_PORTS-1:0][ext_mux_pkg::STRB_W-1:0] s_wstrb_i,
  output logic [ext_mux_pkg::NUM_PORTS-1:0]                     s_bvalid_o,
  input  logic [ext_mux_pkg::NUM_PORTS-1:0]                     s_bready_i,
  output logic [ext_mux_pkg::NUM_PORTS-1:0][1:0]                s_bresp_o,
  // Requester read channels
  input  logic [ext_mux_pkg::NUM_PORTS-1:0]                     s_arvalid_i,
  output logic [ext_mux_pkg::NUM_PORTS-1:0]                     s_arready_o,
  input  logic [ext_mux_pkg::NUM_PORTS-1:0][ext_mux_pkg::ADDR_W-1:0] s_araddr_i,
  output logic [ext_mux_pkg::NUM_PORTS-1:0]                     s_rvalid_o,
  input  logic [ext_mux_pkg::NUM_PORTS-1:0]                     s_rready_i,
  output logic [ext_mux_pkg::NUM_PORTS-1:0][ext_mux_pkg::DATA_W-1:0] s_rdata_o,
  output logic [ext_mux_pkg::NUM_PORTS-1:0][1:0]                s_rresp_o,
  // Subordinate write channels
  output logic                                                  m_awvalid_o,
  input  logic                                                  m_awready_i,
  output logic [ext_mux_pkg::ADDR_W-1:0]                        m_awaddr_o,
  output logic                                                  m_wvalid_o,
  input  logic                                                  m_wready_i,
  output logic [ext_mux_pkg::DATA_W-1:0]                        m_wdata_o,
  output logic [ext_mux_pkg::STRB_W-1:0]                        m_wstrb_o,
  input  logic                                                  m_bvalid_i,
  output logic                                                  m_bready_o,
  input  logic [1:0]                                            m_bresp_i,
  // Subordinate read channels
  output logic                                                  m_arvalid_o,
  input  logic                                                  m_arready_i,
  output logic [ext_mux_pkg::ADDR_W-1:0]                        m_araddr_o,
  input  logic                                                  m_rvalid_i,
  output logic                                                  m_rready_o,
  input  logic [ext_mux_pkg::DATA_W-1:0]                        m_rdata_i,
  input  logic [1:0]                                            m_rresp_i
);

  //////////////////////////////
  // Independent write and read paths
  //////////////////////////////

  // Port names match one to one
  write_mux u_write_mux (
    .*
  );

  read_mux u_read_mux (
    .*
  );

endmodule

//--- test/tb_sub_model.sv
//////////////////////////////
// AXI4-Lite subordinate memory model
// Random ready and response stalls, SLVERR on bit 31
//////////////////////////////

`timescale 1ns/1ps

module tb_sub_model (
  input  logic        periph_clk,
  input  logic        rst_i,
  input  logic        stall_aw_i,
  input  logic        stall_b_i,
  input  logic        stall_ar_i,
  input  logic        stall_r_i,
  input  logic        m_awvalid_i,
  output logic        m_awready_o,
  input  logic [31:0] m_awaddr_i,
  input  logic        m_wvalid_i,
  output logic        m_wready_o,
  input  logic [31:0] m_wdata_i,
  input  logic [3:0]  m_wstrb_i,
  output logic        m_bvalid_o,
  input  logic        m_bready_i,
  output logic [1:0]  m_bresp_o,
  input  logic        m_arvalid_i,
  output logic        m_arready_o,
  input  logic [31:0] m_araddr_i,
  output logic        m_rvalid_o,
  input  logic        m_rready_i,
  output logic [31:0] m_rdata_o,
  output logic [1:0]  m_rresp_o
);

  import ext_mux_pkg::*;

  logic [31:0] mem [logic [31:0]];
  logic [1:0]  b_q [$];
  logic [33:0] r_q [$];  // {resp, data}
  logic        wr_accept;

  // AW and W taken together
  assign wr_accept   = m_awvalid_i & m_wvalid_i & ~stall_aw_i;
  assign m_awready_o = wr_accept;
  assign m_wready_o  = wr_accept;
  assign m_arready_o = m_arvalid_i & ~stall_ar_i;

  always @(posedge periph_clk) begin
    logic [31:0] word;
    if (rst_i) begin
      m_bvalid_o <= 1'b0;
      m_rvalid_o <= 1'b0;
      b_q.delete();
      r_q.delete();
    end else begin
      if (wr_accept) begin
        if (!m_awaddr_i[31]) begin
          word = mem.exists(m_awaddr_i) ? mem[m_awaddr_i] : '0;
          for (int b = 0; b < 4; b++) begin
            if (m_wstrb_i[b]) word[8*b +: 8] = m_wdata_i[8*b +: 8];
          end
          mem[m_awaddr_i] = word;
        end
        b_q.push_back(m_awaddr_i[31] ? RESP_SLVERR : RESP_OKAY);
      end
      if (m_arvalid_i && m_arready_o) begin
        word = mem.exists(m_araddr_i) ? mem[m_araddr_i] : '0;
        r_q.push_back({m_araddr_i[31] ? RESP_SLVERR : RESP_OKAY, word});
      end
      // Responses in order, each held until taken
      if (m_bvalid_o && m_bready_i) begin
        void'(b_q.pop_front());
        m_bvalid_o <= 1'b0;
      end else if (!m_bvalid_o && b_q.size() > 0 && !stall_b_i) begin
        m_bvalid_o <= 1'b1;
        m_bresp_o  <= b_q[0];
      end
      if (m_rvalid_o && m_rready_i) begin
        void'(r_q.pop_front());
        m_rvalid_o <= 1'b0;
      end else if (!m_rvalid_o && r_q.size() > 0 && !stall_r_i) begin
        m_rvalid_o <= 1'b1;
        m_rresp_o  <= r_q[0][33:32];
        m_rdata_o  <= r_q[0][31:0];
      end
    end
  end

endmodule

//--- test/tb_axil_port_mux.sv
//////////////////////////////
// Testbench for the AXI4-Lite port multiplexer
// Port traffic, random stalls, assertions,
// timeout and closing report
//////////////////////////////

`timescale 1ns/1ps

module tb_axil_port_mux;

  import ext_mux_pkg::*;

  localparam int          N_TXN          = 12;  // Per port and direction
  localparam int          ERR_BIT        = 31;
  localparam logic [31:0] SEED           = 32'hebf4_0cd8;
  localparam int          TIMEOUT_CYCLES = 4 * (2 * NUM_PORTS * N_TXN) * 20;

  logic periph_clk;
  logic rst_i;
  logic [NUM_PORTS-1:0]             s_awvalid_i, s_awready_o, s_wvalid_i, s_wready_o;
  logic [NUM_PORTS-1:0][ADDR_W-1:0] s_awaddr_i, s_araddr_i;
  logic [NUM_PORTS-1:0][DATA_W-1:0] s_wdata_i, s_rdata_o;
  logic [NUM_PORTS-1:0][STRB_W-1:0] s_wstrb_i;
  logic [NUM_PORTS-1:0]             s_bvalid_o, s_bready_i, s_arvalid_i, s_arready_o;
  logic [NUM_PORTS-1:0]             s_rvalid_o, s_rready_i;
  logic [NUM_PORTS-1:0][1:0]        s_bresp_o, s_rresp_o;
  logic              m_awvalid_o, m_awready_i, m_wvalid_o, m_wready_i, m_bvalid_i, m_bready_o;
  logic              m_arvalid_o, m_arready_i, m_rvalid_i, m_rready_o;
  logic [ADDR_W-1:0] m_awaddr_o, m_araddr_o;
  logic [DATA_W-1:0] m_wdata_o, m_rdata_i;
  logic [STRB_W-1:0] m_wstrb_o;
  logic [1:0]        m_bresp_i, m_rresp_i;
  logic stall_aw, stall_b, stall_ar, stall_r;

  logic [31:0] lfsr_state = SEED;
  int          cycle_cnt = 0;
  int          assert_errs = 0;
  int          other_errs = 0;
  int          aw_cnt [NUM_PORTS];
  int          b_cnt  [NUM_PORTS];
  int          ar_cnt [NUM_PORTS];
  int          r_cnt  [NUM_PORTS];
  int          m_out_w, m_out_r;  // Downstream in flight
  logic [1:0]  exp_bresp [NUM_PORTS][N_TXN];
  logic [1:0]  exp_rresp [NUM_PORTS][N_TXN];
  logic [31:0] exp_rdata [NUM_PORTS][N_TXN];
  logic [1:0]  bresp_head [NUM_PORTS];
  logic [1:0]  rresp_head [NUM_PORTS];
  logic [31:0] rdata_head [NUM_PORTS];
  logic [31:0] shadow [logic [31:0]];
  logic        seen_valid, have_last, others_waiting;
  logic [1:0]  last_port;

  axil_port_mux u_axil_port_mux (.*);

  tb_sub_model u_sub (
    .periph_clk (periph_clk), .rst_i (rst_i),
    .stall_aw_i (stall_aw), .stall_b_i (stall_b), .stall_ar_i (stall_ar), .stall_r_i (stall_r),
    .m_awvalid_i (m_awvalid_o), .m_awready_o (m_awready_i), .m_awaddr_i (m_awaddr_o),
    .m_wvalid_i (m_wvalid_o), .m_wready_o (m_wready_i), .m_wdata_i (m_wdata_o),
    .m_wstrb_i (m_wstrb_o), .m_bvalid_o (m_bvalid_i), .m_bready_i (m_bready_o),
    .m_bresp_o (m_bresp_i), .m_arvalid_i (m_arvalid_o), .m_arready_o (m_arready_i),
    .m_araddr_i (m_araddr_o), .m_rvalid_o (m_rvalid_i), .m_rready_i (m_rready_o),
    .m_rdata_o (m_rdata_i), .m_rresp_o (m_rresp_i)
  );

  initial begin
    periph_clk = 1'b0;
    forever #20 periph_clk = ~periph_clk;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic take_bit();
    lfsr_state = lfsr_next(lfsr_state);
    return lfsr_state[0];
  endfunction

  // Error flag on ERR_BIT, slot in 9:6, owner port in 5:4
  function automatic logic [31:0] txn_addr(input int p, input int i, input logic err);
    logic [31:0] a;
    a          = {22'd0, 4'(i), 2'(p), 4'd0};
    a[ERR_BIT] = err;
    return a;
  endfunction

  //////////////////////////////
  // Scoreboard state
  //////////////////////////////

  always_comb begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      bresp_head[p] = (b_cnt[p] < N_TXN) ? exp_bresp[p][b_cnt[p]] : 2'b00;
      rresp_head[p] = (r_cnt[p] < N_TXN) ? exp_rresp[p][r_cnt[p]] : 2'b00;
      rdata_head[p] = (r_cnt[p] < N_TXN) ? exp_rdata[p][r_cnt[p]] : '0;
    end
  end

  always_ff @(posedge periph_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (rst_i) begin
      aw_cnt <= '{default: 0};
      b_cnt  <= '{default: 0};
      ar_cnt <= '{default: 0};
      r_cnt  <= '{default: 0};
      m_out_w <= 0;
      m_out_r <= 0;
      seen_valid <= 1'b0;
      have_last  <= 1'b0;
      others_waiting <= 1'b0;
      last_port  <= '0;
    end else begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (s_awvalid_i[p] && s_awready_o[p]) aw_cnt[p] <= aw_cnt[p] + 1;
        if (s_bvalid_o[p] && s_bready_i[p]) b_cnt[p] <= b_cnt[p] + 1;
        if (s_arvalid_i[p] && s_arready_o[p]) ar_cnt[p] <= ar_cnt[p] + 1;
        if (s_rvalid_o[p] && s_rready_i[p]) r_cnt[p] <= r_cnt[p] + 1;
      end
      m_out_w <= m_out_w + int'(m_awvalid_o && m_awready_i) - int'(m_bvalid_i && m_bready_o);
      m_out_r <= m_out_r + int'(m_arvalid_o && m_arready_i) - int'(m_rvalid_i && m_rready_o);
      if (|{s_awvalid_i, s_wvalid_i, s_arvalid_i}) seen_valid <= 1'b1;
      if (m_awvalid_o && m_awready_i) begin
        have_last <= 1'b1;
        last_port <= m_awaddr_o[5:4];
        others_waiting <= |(s_awvalid_i & s_wvalid_i & ~(4'b1 << m_awaddr_o[5:4]));
      end
    end
  end

  //////////////////////////////
  // Assertions
  //////////////////////////////

  assert property (@(posedge periph_clk) disable iff (rst_i)
    !seen_valid |-> !(m_awvalid_o | m_wvalid_o | m_arvalid_o | m_bready_o | m_rready_o) &&
      ({s_awready_o, s_wready_o, s_bvalid_o, s_arready_o, s_rvalid_o} == '0))
    else begin
      assert_errs++;
      $display("FAIL output before any valid, s_awready_o %h s_bvalid_o %h s_rvalid_o %h",
               s_awready_o, s_bvalid_o, s_rvalid_o);
    end

  // Round robin seen through address bits 5:4
  assert property (@(posedge periph_clk) disable iff (rst_i)
    (m_awvalid_o && m_awready_i) |->
      !(have_last && others_waiting && m_awaddr_o[5:4] == last_port))
    else begin
      assert_errs++;
      $display("FAIL m_awaddr_o %h won again while others waited, last port %h",
               m_awaddr_o, last_port);
    end

  assert property (@(posedge periph_clk) disable iff (rst_i) m_out_w <= int'(MAX_OUTSTANDING))
    else begin
      assert_errs++;
      $display("FAIL m_out_w %h over limit %h", m_out_w, MAX_OUTSTANDING);
    end

  assert property (@(posedge periph_clk) disable iff (rst_i) m_out_r <= int'(MAX_OUTSTANDING))
    else begin
      assert_errs++;
      $display("FAIL m_out_r %h over limit %h", m_out_r, MAX_OUTSTANDING);
    end

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port_chk
    assert property (@(posedge periph_clk) disable iff (rst_i)
      s_bvalid_o[p] |-> b_cnt[p] < aw_cnt[p])
      else begin
        assert_errs++;
        $display("FAIL s_bvalid_o[%0d] %h with no write from that port", p, s_bvalid_o[p]);
      end
    assert property (@(posedge periph_clk) disable iff (rst_i)
      (s_bvalid_o[p] && s_bready_i[p]) |-> s_bresp_o[p] == bresp_head[p])
      else begin
        assert_errs++;
        $display("FAIL s_bresp_o[%0d] got %h expected %h", p, s_bresp_o[p], bresp_head[p]);
      end
    assert property (@(posedge periph_clk) disable iff (rst_i)
      s_rvalid_o[p] |-> r_cnt[p] < ar_cnt[p])
      else begin
        assert_errs++;
        $display("FAIL s_rvalid_o[%0d] %h with no read from that port", p, s_rvalid_o[p]);
      end
    assert property (@(posedge periph_clk) disable iff (rst_i)
      (s_rvalid_o[p] && s_rready_i[p]) |-> s_rresp_o[p] == rresp_head[p])
      else begin
        assert_errs++;
        $display("FAIL s_rresp_o[%0d] got %h expected %h", p, s_rresp_o[p], rresp_head[p]);
      end
    assert property (@(posedge periph_clk) disable iff (rst_i)
      (s_rvalid_o[p] && s_rready_i[p] && rresp_head[p] == RESP_OKAY) |->
        s_rdata_o[p] == rdata_head[p])
      else begin
        assert_errs++;
        $display("FAIL s_rdata_o[%0d] got %h expected %h", p, s_rdata_o[p], rdata_head[p]);
      end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  task automatic write_port(input int p);
    logic [31:0] addr;
    logic [31:0] data;
    logic        err;
    logic        aw_ok;
    logic        w_ok;
    for (int i = 0; i < N_TXN; i++) begin
      err  = (i % 5 == 3);
      addr = txn_addr(p, i, err);
      data = {8'(p + 1), 8'(i), 16'h5a3c};
      exp_bresp[p][i] = err ? RESP_SLVERR : RESP_OKAY;
      if (!err) shadow[addr] = data;
      s_awaddr_i[p]  = addr;
      s_wdata_i[p]   = data;
      s_wstrb_i[p]   = '1;
      s_awvalid_i[p] = 1'b1;
      s_wvalid_i[p]  = 1'b1;
      do begin
        @(negedge periph_clk);  // Stable mid cycle
        aw_ok = s_awready_o[p];
        w_ok  = s_wready_o[p];
        @(posedge periph_clk);
        #2;
        if (aw_ok) s_awvalid_i[p] = 1'b0;
        if (w_ok) s_wvalid_i[p] = 1'b0;
      end while (s_awvalid_i[p] || s_wvalid_i[p]);
    end
    while (b_cnt[p] < N_TXN) @(posedge periph_clk);
    #2;
  endtask

  // Even slots read own writes, odd slots the next port's
  task automatic read_port(input int p);
    logic [31:0] addr;
    logic        err;
    logic        ar_ok;
    int          q;
    for (int i = 0; i < N_TXN; i++) begin
      q    = (i % 2 == 0) ? p : (p + 1) % NUM_PORTS;
      err  = (i % 5 == 3);
      addr = txn_addr(q, i, err);
      exp_rresp[p][i] = err ? RESP_SLVERR : RESP_OKAY;
      exp_rdata[p][i] = shadow.exists(addr) ? shadow[addr] : '0;
      s_araddr_i[p]  = addr;
      s_arvalid_i[p] = 1'b1;
      do begin
        @(negedge periph_clk);
        ar_ok = s_arready_o[p];
        @(posedge periph_clk);
        #2;
        if (ar_ok) s_arvalid_i[p] = 1'b0;
      end while (s_arvalid_i[p]);
    end
    while (r_cnt[p] < N_TXN) @(posedge periph_clk);
    #2;
  endtask

  // Random stalls, long response stalls in windows to fill the FIFOs
  initial begin
    forever begin
      @(posedge periph_clk);
      #2;
      stall_aw = take_bit() & take_bit();
      stall_ar = take_bit() & take_bit();
      stall_b  = take_bit() | (cycle_cnt % 128 >= 32 && cycle_cnt % 128 < 72);
      stall_r  = take_bit() | (cycle_cnt % 128 >= 32 && cycle_cnt % 128 < 72);
      for (int p = 0; p < NUM_PORTS; p++) begin
        s_bready_i[p] = take_bit();
        s_rready_i[p] = take_bit();
      end
    end
  end

  initial begin
    while (cycle_cnt < TIMEOUT_CYCLES) @(posedge periph_clk);
    $display("Timeout after %0d cycles, transactions did not finish", cycle_cnt);
    $display("test failed");
    $finish;
  end

  initial begin
    rst_i = 1'b1;
    {s_awvalid_i, s_wvalid_i, s_arvalid_i, s_bready_i, s_rready_i} = '0;
    s_awaddr_i = '0;
    s_araddr_i = '0;
    s_wdata_i  = '0;
    s_wstrb_i  = '0;
    {stall_aw, stall_b, stall_ar, stall_r} = 4'hf;
    repeat (3) @(posedge periph_clk);
    #2;
    rst_i = 1'b0;
    repeat (2) @(posedge periph_clk);
    #2;
    fork
      write_port(0);
      write_port(1);
      write_port(2);
      write_port(3);
    join
    fork
      read_port(0);
      read_port(1);
      read_port(2);
      read_port(3);
    join
    repeat (5) @(posedge periph_clk);
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (aw_cnt[p] != b_cnt[p] || ar_cnt[p] != r_cnt[p]) begin
        other_errs++;
        $display("Port %0d requests and responses do not match", p);
      end
    end
    $display("Errors: %0d assertion failures, %0d other failures", assert_errs, other_errs);
    if (assert_errs + other_errs == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- list.f
logic/ext_mux_pkg.sv
logic/rr_arbiter.sv
logic/source_fifo.sv
logic/write_mux.sv
logic/read_mux.sv
logic/axil_port_mux.sv
test/tb_sub_model.sv
test/tb_axil_port_mux.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the AXI4-Lite port multiplexer testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_axil_port_mux \
  -f list.f

sim_out=$(./obj_dir/Vtb_axil_port_mux)
echo "$sim_out"

if grep -q "test passed" <<< "$sim_out"; then
  exit 0
else
  exit 1
fi
